// ==== hv/owt_rx_pkg.sv ====
// one-wire receiver shared definitions
// field widths, frame states, symbol classes and error-counter tables

package owt_rx_pkg;

    localparam int CMD_W      = 8;
    localparam int CRC_W      = 8;
    localparam int SYNC_EDGES = 8;
    localparam int ERR_CNT_W  = 4;

    // crc-8, msb first, zero seed
    localparam logic [CRC_W-1:0] CRC_POLY = 8'h07;

    // low command bits of a read that carries no data field
    localparam logic [CMD_W-2:0] SHORT_RD_CODE = 7'h7f;

    typedef enum logic [2:0] {
        IDLE,
        SYNC_HEAD,
        SYNC_TAIL,
        CMD,
        DATA,
        CRC,
        END_TAIL
    } owt_state_e;

    // interval length in units of T
    typedef enum logic [1:0] {
        NONE,
        ONE,
        TWO,
        THREE
    } sym_class_e;

    localparam logic [ERR_CNT_W-1:0] ERR_INIT = 4'd8;
    localparam logic [ERR_CNT_W-1:0] ERR_MAX  = 4'd15;

    // steps picked by config[3:2] and config[1:0]
    localparam logic [ERR_CNT_W-1:0] ERR_ADD_TBL [4] = '{4'd1, 4'd2, 4'd4, 4'd8};
    localparam logic [ERR_CNT_W-1:0] COR_SUB_TBL [4] = '{4'd1, 4'd2, 4'd4, 4'd8};

endpackage

// ==== hv/owt_sym_if.sv ====
// classed symbol and edge bus from the symbol timer to decoder and frame FSM

`timescale 1ns/1ps

interface owt_sym_if
    import owt_rx_pkg::*;
#(
    parameter int SYM_CNT_W = 8
) ();

    logic                 sym_vld;
    sym_class_e           sym_class;
    // running interval count, saturates on a stalled line
    logic [SYM_CNT_W-1:0] sym_len;
    logic                 rx_pos;
    logic                 rx_neg;

    modport timer   (output sym_vld, sym_class, sym_len, rx_pos, rx_neg);
    modport decoder (input sym_vld, sym_class, rx_pos, rx_neg);
    modport fsm     (input sym_len, rx_pos, rx_neg);

endinterface

// ==== hv/owt_symbol_timer.sv ====
// symbol timer: synchronises the line, finds its edges, learns the unit T
// from the preamble and classes every later interval as 1, 2 or 3 units

`timescale 1ns/1ps

module owt_symbol_timer
    import owt_rx_pkg::*;
#(
    parameter int SYM_CNT_W = 8
) (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_rx,
    input  logic     i_idle,
    input  logic     i_train,
    owt_sym_if.timer sym
);

    localparam int TH_W = SYM_CNT_W + 2;

    logic [1:0]           rx_sync;
    logic                 rx_line_q;
    logic                 pos_q;
    logic                 neg_q;
    logic                 measuring;
    logic                 edge_seen;
    logic                 sym_vld_w;
    logic [SYM_CNT_W-1:0] len_cnt;
    logic [SYM_CNT_W-1:0] unit_q;
    logic [SYM_CNT_W:0]   len_sum;
    logic [TH_W-1:0]      half_unit;
    logic [TH_W-1:0]      one_up_th;
    logic [TH_W-1:0]      two_up_th;

    assign edge_seen = pos_q | neg_q;
    assign sym_vld_w = edge_seen & measuring;
    assign len_sum   = {1'b0, len_cnt} + {1'b0, unit_q};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_sync   <= 2'b00;
            rx_line_q <= 1'b0;
            pos_q     <= 1'b0;
            neg_q     <= 1'b0;
            measuring <= 1'b0;
            len_cnt   <= '0;
            unit_q    <= '0;
        end else begin
            rx_sync   <= {rx_sync[0], i_rx};
            rx_line_q <= rx_sync[1];
            pos_q     <= rx_sync[1] & ~rx_line_q;
            neg_q     <= ~rx_sync[1] & rx_line_q;
            // first rising edge after idle opens the measurement
            if (pos_q) begin
                measuring <= 1'b1;
            end else if (i_idle) begin
                measuring <= 1'b0;
            end
            if (edge_seen) begin
                len_cnt <= SYM_CNT_W'(1);
            end else if (measuring && (len_cnt != '1)) begin
                len_cnt <= len_cnt + 1'b1;
            end
            // first preamble interval loads T, the rest are averaged in
            if (i_idle) begin
                unit_q <= '0;
            end else if (i_train && sym_vld_w) begin
                unit_q <= (unit_q == '0) ? len_cnt : len_sum[SYM_CNT_W:1];
            end
        end
    end

    // ========================================================================
    // interval classing at 1.5T and 2.5T
    // ========================================================================
    assign half_unit = ({2'b00, unit_q} + TH_W'(1)) >> 1;
    assign one_up_th = {2'b00, unit_q} + half_unit;
    assign two_up_th = {1'b0, unit_q, 1'b0} + half_unit;

    always_comb begin
        if (!sym_vld_w) begin
            sym.sym_class = NONE;
        end else if ({2'b00, len_cnt} <= one_up_th) begin
            sym.sym_class = ONE;
        end else if ({2'b00, len_cnt} <= two_up_th) begin
            sym.sym_class = TWO;
        end else begin
            sym.sym_class = THREE;
        end
    end

    assign sym.sym_vld = sym_vld_w;
    assign sym.sym_len = len_cnt;
    assign sym.rx_pos  = pos_q;
    assign sym.rx_neg  = neg_q;

endmodule

// ==== hv/owt_mcst_decoder.sv ====
// Manchester decoder: follows the bit phase over classed intervals and turns
// mid-bit edges into bits, flagging intervals that break the coding

`timescale 1ns/1ps

module owt_mcst_decoder
    import owt_rx_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    owt_sym_if.decoder sym,
    input  logic       i_active,
    input  logic       i_first,
    output logic       o_bit_vld,
    output logic       o_bit_val,
    output logic       o_code_err
);

    logic is_one;
    logic is_two;
    logic is_three;
    // set once the last edge sat in the middle of a bit
    logic mid_q;
    logic bit_hit;
    logic bad_code;

    assign is_one   = sym.sym_vld && (sym.sym_class == ONE);
    assign is_two   = sym.sym_vld && (sym.sym_class == TWO);
    assign is_three = sym.sym_vld && (sym.sym_class == THREE);

    // long intervals from a boundary are only legal right after the tail
    assign bad_code = i_active && ((!mid_q && !i_first && (is_two || is_three)) ||
                                   (is_three && sym.rx_neg));
    assign bit_hit  = i_active && !bad_code && ((is_one && !mid_q) || (is_two && mid_q) ||
                                                (is_three && sym.rx_pos));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mid_q      <= 1'b0;
            o_bit_vld  <= 1'b0;
            o_code_err <= 1'b0;
        end else begin
            o_bit_vld  <= bit_hit;
            o_code_err <= bad_code;
            if (!i_active) begin
                mid_q <= 1'b0;
            end else if (is_one) begin
                mid_q <= !mid_q;
            end else if (is_three && sym.rx_pos) begin
                mid_q <= 1'b1;
            end
        end
    end

    // falling mid-bit edge is a 1
    always_ff @(posedge i_clk) begin
        if (bit_hit) begin
            o_bit_val <= sym.rx_neg;
        end
    end

endmodule

// ==== hv/owt_crc8_serial.sv ====
// bit-serial CRC-8 generator, msb first

`timescale 1ns/1ps

module owt_crc8_serial
    import owt_rx_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_start,
    input  logic             i_vld,
    input  logic             i_bit,
    output logic [CRC_W-1:0] o_crc
);

    logic [CRC_W-1:0] crc_seed;
    logic             feedback;

    // start restarts from zero together with the first bit
    assign crc_seed = i_start ? '0 : o_crc;
    assign feedback = crc_seed[CRC_W-1] ^ i_bit;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_crc <= '0;
        end else if (i_vld) begin
            o_crc <= {crc_seed[CRC_W-2:0], 1'b0} ^ (feedback ? CRC_POLY : '0);
        end
    end

endmodule

// ==== hv/owt_frame_fsm.sv ====
// frame FSM: walks preamble, tail and the command, data and crc fields,
// shifts the field bits, runs the frame timeout and reports each frame

`timescale 1ns/1ps

module owt_frame_fsm
    import owt_rx_pkg::*;
#(
    parameter int DATA_W     = 16,
    parameter int RX_TMO_CYC = 4000
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    owt_sym_if.fsm            sym,
    input  logic              i_bit_vld,
    input  logic              i_bit_val,
    input  logic              i_code_err,
    output logic              o_idle,
    output logic              o_train,
    output logic              o_active,
    output logic              o_first,
    output logic              o_rx_vld,
    output logic              o_rx_status,
    output logic              o_rst_wdg,
    output logic [CMD_W-1:0]  o_rx_cmd,
    output logic [DATA_W-1:0] o_rx_data,
    output logic [CRC_W-1:0]  o_rx_crc
);

    localparam int CNT_MAX = (DATA_W > SYNC_EDGES) ? DATA_W : SYNC_EDGES;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);
    localparam int TMO_W   = $clog2(RX_TMO_CYC + 1);

    owt_state_e       state_q;
    owt_state_e       field_nxt;
    logic [CNT_W-1:0] cnt_q;
    logic [TMO_W-1:0] tmo_cnt;
    logic [CMD_W-1:0] cmd_shift;
    logic [CRC_W-1:0] crc_calc;
    logic             field_last;
    logic             short_rd;
    logic             tmo_hit;
    logic             line_stall;
    logic             abort;
    logic             finish;
    logic             crc_ok;

    assign cmd_shift  = {o_rx_cmd[CMD_W-2:0], i_bit_val};
    assign short_rd   = !cmd_shift[CMD_W-1] && (cmd_shift[CMD_W-2:0] == SHORT_RD_CODE);
    assign tmo_hit    = (tmo_cnt == TMO_W'(RX_TMO_CYC - 1));
    // symbol counter ran out, the line has stopped mid-frame
    assign line_stall = (sym.sym_len == '1);
    assign abort      = (state_q != IDLE) && (i_code_err || tmo_hit || line_stall);
    assign finish     = (state_q == END_TAIL) && sym.rx_neg;
    assign crc_ok     = (crc_calc == o_rx_crc);

    always_comb begin
        field_last = 1'b0;
        field_nxt  = IDLE;
        case (state_q)
            CMD: begin
                field_last = (cnt_q == CNT_W'(CMD_W - 1));
                field_nxt  = short_rd ? CRC : DATA;
            end
            DATA: begin
                field_last = (cnt_q == CNT_W'(DATA_W - 1));
                field_nxt  = CRC;
            end
            CRC: begin
                field_last = (cnt_q == CNT_W'(CRC_W - 1));
                field_nxt  = END_TAIL;
            end
            default: field_nxt = IDLE;
        endcase
    end

    // ========================================================================
    // state, edge and bit counter, frame timeout
    // ========================================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            tmo_cnt <= '0;
        end else begin
            tmo_cnt <= (state_q == IDLE) ? '0 : tmo_cnt + 1'b1;
            if (abort) begin
                state_q <= IDLE;
                cnt_q   <= '0;
            end else begin
                case (state_q)
                    IDLE: begin
                        if (sym.rx_pos) begin
                            state_q <= SYNC_HEAD;
                            cnt_q   <= CNT_W'(1);
                        end
                    end
                    // the rise after the last preamble edge opens the tail
                    SYNC_HEAD: begin
                        if (sym.rx_pos && (cnt_q == CNT_W'(SYNC_EDGES))) begin
                            state_q <= SYNC_TAIL;
                            cnt_q   <= '0;
                        end else if (sym.rx_pos) begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                    SYNC_TAIL: begin
                        if (sym.rx_neg) begin
                            state_q <= CMD;
                        end
                    end
                    CMD, DATA, CRC: begin
                        if (i_bit_vld && field_last) begin
                            state_q <= field_nxt;
                            cnt_q   <= '0;
                        end else if (i_bit_vld) begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                    END_TAIL: begin
                        if (sym.rx_neg) begin
                            state_q <= IDLE;
                        end
                    end
                    default: state_q <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_bit_vld) begin
            case (state_q)
                CMD:     o_rx_cmd  <= cmd_shift;
                DATA:    o_rx_data <= {o_rx_data[DATA_W-2:0], i_bit_val};
                CRC:     o_rx_crc  <= {o_rx_crc[CRC_W-2:0], i_bit_val};
                default: ;
            endcase
        end
    end

    // crc runs over command and data bits
    owt_crc8_serial u_crc (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (i_bit_vld && o_first),
        .i_vld   (i_bit_vld && ((state_q == CMD) || (state_q == DATA))),
        .i_bit   (i_bit_val),
        .o_crc   (crc_calc)
    );

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rx_vld    <= 1'b0;
            o_rx_status <= 1'b0;
            o_rst_wdg   <= 1'b0;
        end else begin
            o_rx_vld  <= abort || finish;
            o_rst_wdg <= finish && !abort && crc_ok;
            if (abort || finish) begin
                o_rx_status <= abort || !crc_ok;
            end
        end
    end

    // edge count stays within 1 to SYNC_EDGES while in the preamble
    assign o_idle   = (state_q == IDLE);
    assign o_train  = (state_q == SYNC_HEAD);
    assign o_active = (state_q == CMD) || (state_q == DATA) || (state_q == CRC);
    assign o_first  = (state_q == CMD) && (cnt_q == '0);

endmodule

// ==== hv/owt_com_err_mon.sv ====
// communication-error monitor: saturating counter stepped by frame results,
// compared against a mode-dependent level

`timescale 1ns/1ps

module owt_com_err_mon
    import owt_rx_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_done,
    input  logic       i_status,
    input  logic       i_mode,
    input  logic [3:0] i_config,
    output logic       o_com_err
);

    logic [ERR_CNT_W-1:0] err_cnt;
    logic [ERR_CNT_W-1:0] cnt_nxt;
    logic [ERR_CNT_W-1:0] add_step;
    logic [ERR_CNT_W-1:0] sub_step;
    logic [ERR_CNT_W:0]   cnt_sum;

    assign add_step = ERR_ADD_TBL[i_config[3:2]];
    assign sub_step = COR_SUB_TBL[i_config[1:0]];
    assign cnt_sum  = {1'b0, err_cnt} + {1'b0, add_step};

    always_comb begin
        cnt_nxt = err_cnt;
        if (i_done && i_status) begin
            cnt_nxt = (cnt_sum >= {1'b0, ERR_MAX}) ? ERR_MAX : cnt_sum[ERR_CNT_W-1:0];
        end else if (i_done) begin
            cnt_nxt = (sub_step >= err_cnt) ? '0 : err_cnt - sub_step;
        end
    end

    // mode 1 flags an empty counter, mode 0 a count at or above the add step
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            err_cnt   <= ERR_INIT;
            o_com_err <= 1'b1;
        end else begin
            err_cnt   <= cnt_nxt;
            o_com_err <= i_mode ? (cnt_nxt == '0) : (cnt_nxt >= add_step);
        end
    end

endmodule

// ==== hv/owt_rx_top.sv ====
// one-wire Manchester command receiver, top level
// symbol timer, decoder, frame FSM and communication-error monitor

`timescale 1ns/1ps

module owt_rx_top
    import owt_rx_pkg::*;
#(
    parameter int DATA_W     = 16,
    parameter int SYM_CNT_W  = 8,
    parameter int RX_TMO_CYC = 4000
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_rx,
    input  logic              i_comerr_mode,
    input  logic [3:0]        i_comerr_config,
    output logic              o_rx_vld,
    output logic              o_rx_status,
    output logic [CMD_W-1:0]  o_rx_cmd,
    output logic [DATA_W-1:0] o_rx_data,
    output logic [CRC_W-1:0]  o_rx_crc,
    output logic              o_rst_wdg,
    output logic              o_com_err
);

    logic fsm_idle;
    logic fsm_train;
    logic fsm_active;
    logic fsm_first;
    logic bit_vld;
    logic bit_val;
    logic code_err;

    owt_sym_if #(.SYM_CNT_W(SYM_CNT_W)) sym_bus ();

    owt_symbol_timer #(.SYM_CNT_W(SYM_CNT_W)) u_timer (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_rx    (i_rx),
        .i_idle  (fsm_idle),
        .i_train (fsm_train),
        .sym     (sym_bus.timer)
    );

    owt_mcst_decoder u_decoder (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .sym        (sym_bus.decoder),
        .i_active   (fsm_active),
        .i_first    (fsm_first),
        .o_bit_vld  (bit_vld),
        .o_bit_val  (bit_val),
        .o_code_err (code_err)
    );

    owt_frame_fsm #(
        .DATA_W     (DATA_W),
        .RX_TMO_CYC (RX_TMO_CYC)
    ) u_fsm (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .sym         (sym_bus.fsm),
        .i_bit_vld   (bit_vld),
        .i_bit_val   (bit_val),
        .i_code_err  (code_err),
        .o_idle      (fsm_idle),
        .o_train     (fsm_train),
        .o_active    (fsm_active),
        .o_first     (fsm_first),
        .o_rx_vld    (o_rx_vld),
        .o_rx_status (o_rx_status),
        .o_rst_wdg   (o_rst_wdg),
        .o_rx_cmd    (o_rx_cmd),
        .o_rx_data   (o_rx_data),
        .o_rx_crc    (o_rx_crc)
    );

    owt_com_err_mon u_err_mon (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_done    (o_rx_vld),
        .i_status  (o_rx_status),
        .i_mode    (i_comerr_mode),
        .i_config  (i_comerr_config),
        .o_com_err (o_com_err)
    );

endmodule

// ==== bench/owt_rx_tb.sv ====
// testbench for the one-wire Manchester command receiver
// drives framed line waveforms, checks frame results and the error level

`timescale 1ns/1ps

module owt_rx_tb
    import owt_rx_pkg::*;
();

    localparam int DATA_W      = 16;
    localparam int SYM_CNT_W   = 8;
    localparam int RX_TMO_CYC  = 4000;
    localparam int T_CYC       = 8;
    localparam int GAP_T       = 4;
    localparam int RESULT_WAIT = 8;
    localparam int DRAIN_CYC   = 400;
    localparam int N_FRAMES    = 15;
    localparam int FRAME_CYC   = T_CYC * (GAP_T + 2 * SYNC_EDGES + 4 +
                                          2 * (CMD_W + DATA_W + CRC_W) + 2);
    localparam int WATCHDOG_CYC = N_FRAMES * FRAME_CYC + RX_TMO_CYC + 2 * DRAIN_CYC + 2000;

    // crc-8 x^8+x^2+x+1, zero seed, msb first
    localparam logic [7:0] REF_POLY  = 8'h07;
    localparam int         CNT_RESET = 8;
    localparam int         CNT_SAT   = 15;

    typedef struct packed {
        logic              status;
        logic              wdg;
        logic [CMD_W-1:0]  cmd;
        logic [DATA_W-1:0] data;
        logic [CRC_W-1:0]  crc;
    } frame_res_t;

    logic              i_clk;
    logic              i_rst_n;
    logic              i_rx;
    logic              i_comerr_mode;
    logic [3:0]        i_comerr_config;
    logic              o_rx_vld;
    logic              o_rx_status;
    logic [CMD_W-1:0]  o_rx_cmd;
    logic [DATA_W-1:0] o_rx_data;
    logic [CRC_W-1:0]  o_rx_crc;
    logic              o_rst_wdg;
    logic              o_com_err;

    frame_res_t        results [$];
    logic [DATA_W-1:0] last_data;
    integer            seed = 32'hfce3;
    int                err_count = 0;
    int                tests_run = 0;
    int                tests_failed = 0;

    owt_rx_top #(
        .DATA_W     (DATA_W),
        .SYM_CNT_W  (SYM_CNT_W),
        .RX_TMO_CYC (RX_TMO_CYC)
    ) dut_i (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_rx            (i_rx),
        .i_comerr_mode   (i_comerr_mode),
        .i_comerr_config (i_comerr_config),
        .o_rx_vld        (o_rx_vld),
        .o_rx_status     (o_rx_status),
        .o_rx_cmd        (o_rx_cmd),
        .o_rx_data       (o_rx_data),
        .o_rx_crc        (o_rx_crc),
        .o_rst_wdg       (o_rst_wdg),
        .o_com_err       (o_com_err)
    );

    always #50 i_clk = ~i_clk;

    // frame results are captured mid-cycle
    always @(negedge i_clk) begin
        if (i_rst_n && o_rx_vld) begin
            results.push_back({o_rx_status, o_rst_wdg, o_rx_cmd, o_rx_data, o_rx_crc});
        end
        if (i_rst_n) begin
            assert (o_rx_vld || !o_rst_wdg) else begin
                $display("%0t: watchdog kick seen without a frame result", $time);
                err_count++;
            end
        end
    end

    // ========================================================================
    // reference models
    // ========================================================================
    function automatic logic [CRC_W-1:0] ref_crc(input logic [CMD_W-1:0] cmd,
                                                 input logic [DATA_W-1:0] data,
                                                 input bit short_rd);
        logic [CRC_W-1:0]        crc;
        logic [CMD_W+DATA_W-1:0] stream;
        int                      nbits;
        crc    = '0;
        stream = {cmd, data};
        nbits  = short_rd ? CMD_W : CMD_W + DATA_W;
        for (int i = 0; i < nbits; i++) begin
            if (crc[CRC_W-1] ^ stream[CMD_W+DATA_W-1-i]) begin
                crc = {crc[CRC_W-2:0], 1'b0} ^ REF_POLY;
            end else begin
                crc = {crc[CRC_W-2:0], 1'b0};
            end
        end
        return crc;
    endfunction

    // steps are 1, 2, 4, 8 by select
    function automatic int next_count(input int cnt, input logic bad, input logic [3:0] cfg);
        int add_step;
        int sub_step;
        add_step = 1 << cfg[3:2];
        sub_step = 1 << cfg[1:0];
        if (bad) begin
            return (cnt + add_step > CNT_SAT) ? CNT_SAT : cnt + add_step;
        end
        return (cnt - sub_step < 0) ? 0 : cnt - sub_step;
    endfunction

    function automatic logic expect_com_err(input int cnt, input logic mode,
                                            input logic [3:0] cfg);
        int add_step;
        add_step = 1 << cfg[3:2];
        return mode ? (cnt == 0) : (cnt >= add_step);
    endfunction

    // ========================================================================
    // line driver and result helpers
    // ========================================================================
    task automatic hold_line(input logic level, input int units);
        i_rx = level;
        repeat (units * T_CYC) @(negedge i_clk);
    endtask

    task automatic send_frame(input logic [CMD_W-1:0] cmd, input logic [DATA_W-1:0] data,
                              input bit short_rd = 1'b0, input bit flip_crc = 1'b0,
                              input int break_idx = -1, input bit stop_after_cmd = 1'b0);
        logic [CRC_W-1:0] crc;
        bit               bits [$];
        int               n_sent;
        crc = ref_crc(cmd, data, short_rd);
        if (flip_crc) begin
            crc[0] = ~crc[0];
        end
        for (int i = CMD_W - 1; i >= 0; i--) begin
            bits.push_back(cmd[i]);
        end
        if (!short_rd) begin
            for (int i = DATA_W - 1; i >= 0; i--) begin
                bits.push_back(data[i]);
            end
        end
        for (int i = CRC_W - 1; i >= 0; i--) begin
            bits.push_back(crc[i]);
        end
        n_sent = stop_after_cmd ? CMD_W : bits.size();
        @(negedge i_clk);
        hold_line(1'b0, GAP_T);
        // preamble then tail
        for (int i = 0; i < SYNC_EDGES; i++) begin
            hold_line(1'b1, 1);
            hold_line(1'b0, 1);
        end
        hold_line(1'b1, 2);
        hold_line(1'b0, 2);
        for (int i = 0; i < n_sent; i++) begin
            if (i == break_idx) begin
                // flip at the boundary, then no mid-bit edge for 3T
                hold_line(~i_rx, 3);
            end else begin
                hold_line(bits[i], 1);
                hold_line(~bits[i], 1);
            end
        end
        if (!stop_after_cmd) begin
            hold_line(1'b1, 2);
        end
        i_rx = 1'b0;
    endtask

    task automatic get_result(input int limit, output frame_res_t res, output bit got);
        int n;
        n = 0;
        while ((results.size() == 0) && (n < limit)) begin
            @(posedge i_clk);
            n++;
        end
        got = (results.size() != 0);
        res = '0;
        if (got) begin
            res = results.pop_front();
        end
        assert (got) else begin
            $display("%0t: no frame result within %0d cycles", $time, limit);
            err_count++;
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic drain_results();
        repeat (DRAIN_CYC) @(negedge i_clk);
        results.delete();
    endtask

    task automatic apply_reset();
        @(negedge i_clk);
        i_rst_n = 1'b0;
        results.delete();
        repeat (8) @(negedge i_clk);
        i_rst_n = 1'b1;
    endtask

    task automatic report_test(input string name, input int errs0);
        tests_run++;
        if (err_count == errs0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d failed checks", name, err_count - errs0);
        end
    endtask

    // ========================================================================
    // directed tests
    // ========================================================================
    task automatic test_good_frames();
        int                errs0;
        logic [CMD_W-1:0]  cmd;
        logic [DATA_W-1:0] data;
        frame_res_t        res;
        bit                got;
        errs0 = err_count;
        for (int k = 0; k < 4; k++) begin
            // msb set keeps these away from the short read code
            cmd  = CMD_W'($random(seed)) | 8'h80;
            data = DATA_W'($random(seed));
            send_frame(cmd, data);
            get_result(RESULT_WAIT, res, got);
            if (got) begin
                check_val("o_rx_status", 32'(res.status), 32'd0);
                check_val("o_rst_wdg", 32'(res.wdg), 32'd1);
                check_val("o_rx_cmd", 32'(res.cmd), 32'(cmd));
                check_val("o_rx_data", 32'(res.data), 32'(data));
                check_val("o_rx_crc", 32'(res.crc), 32'(ref_crc(cmd, data, 1'b0)));
            end
            last_data = data;
        end
        report_test("good frames", errs0);
    endtask

    task automatic test_short_read();
        int         errs0;
        frame_res_t res;
        bit         got;
        errs0 = err_count;
        send_frame(8'h7f, '0, 1'b1);
        get_result(RESULT_WAIT, res, got);
        if (got) begin
            check_val("o_rx_status", 32'(res.status), 32'd0);
            check_val("o_rst_wdg", 32'(res.wdg), 32'd1);
            check_val("o_rx_cmd", 32'(res.cmd), 32'h7f);
            check_val("o_rx_crc", 32'(res.crc), 32'(ref_crc(8'h7f, '0, 1'b1)));
            // no data bits, so the last data field is still held
            check_val("o_rx_data", 32'(res.data), 32'(last_data));
        end
        report_test("short read", errs0);
    endtask

    task automatic test_bad_crc();
        int                errs0;
        logic [CMD_W-1:0]  cmd;
        logic [DATA_W-1:0] data;
        frame_res_t        res;
        bit                got;
        errs0 = err_count;
        cmd  = CMD_W'($random(seed)) | 8'h80;
        data = DATA_W'($random(seed));
        send_frame(cmd, data, 1'b0, 1'b1);
        get_result(RESULT_WAIT, res, got);
        if (got) begin
            check_val("o_rx_status", 32'(res.status), 32'd1);
            check_val("o_rst_wdg", 32'(res.wdg), 32'd0);
            check_val("o_rx_cmd", 32'(res.cmd), 32'(cmd));
            check_val("o_rx_data", 32'(res.data), 32'(data));
        end
        report_test("bad crc", errs0);
    endtask

    task automatic test_coding_and_timeout();
        int                errs0;
        logic [CMD_W-1:0]  cmd;
        logic [DATA_W-1:0] data;
        frame_res_t        res;
        bit                got;
        errs0 = err_count;
        cmd  = CMD_W'($random(seed)) | 8'h80;
        data = DATA_W'($random(seed));
        send_frame(cmd, data, 1'b0, 1'b0, CMD_W + 5);
        get_result(RESULT_WAIT, res, got);
        if (got) begin
            check_val("o_rx_status", 32'(res.status), 32'd1);
            check_val("o_rst_wdg", 32'(res.wdg), 32'd0);
        end
        // rest of the broken frame may be seen as a new one
        drain_results();
        send_frame(cmd, data, 1'b0, 1'b0, -1, 1'b1);
        get_result(RX_TMO_CYC + 100, res, got);
        if (got) begin
            check_val("o_rx_status", 32'(res.status), 32'd1);
            check_val("o_rst_wdg", 32'(res.wdg), 32'd0);
        end
        drain_results();
        report_test("coding error and line stop", errs0);
    endtask

    task automatic counted_frame(input logic bad, inout int model_cnt);
        logic [CMD_W-1:0]  cmd;
        logic [DATA_W-1:0] data;
        frame_res_t        res;
        bit                got;
        cmd  = CMD_W'($random(seed)) | 8'h80;
        data = DATA_W'($random(seed));
        send_frame(cmd, data, 1'b0, bad);
        get_result(RESULT_WAIT, res, got);
        if (got) begin
            check_val("o_rx_status", 32'(res.status), 32'(bad));
        end
        model_cnt = next_count(model_cnt, bad, i_comerr_config);
        @(negedge i_clk);
        check_val("o_com_err", 32'(o_com_err),
                  32'(expect_com_err(model_cnt, i_comerr_mode, i_comerr_config)));
    endtask

    task automatic test_err_counter();
        int errs0;
        int model_cnt;
        errs0 = err_count;
        // add 8, subtract 1
        i_comerr_mode   = 1'b0;
        i_comerr_config = 4'b1100;
        apply_reset();
        check_val("o_rx_vld", 32'(o_rx_vld), 32'd0);
        check_val("o_rx_status", 32'(o_rx_status), 32'd0);
        check_val("o_rst_wdg", 32'(o_rst_wdg), 32'd0);
        check_val("o_com_err", 32'(o_com_err), 32'd1);
        model_cnt = CNT_RESET;
        @(negedge i_clk);
        check_val("o_com_err", 32'(o_com_err), 32'(expect_com_err(model_cnt, 1'b0, 4'b1100)));
        counted_frame(1'b0, model_cnt);
        counted_frame(1'b0, model_cnt);
        counted_frame(1'b1, model_cnt);
        // mode 1 with subtract 8 to reach zero quickly
        i_comerr_mode   = 1'b1;
        i_comerr_config = 4'b1111;
        @(negedge i_clk);
        check_val("o_com_err", 32'(o_com_err), 32'(expect_com_err(model_cnt, 1'b1, 4'b1111)));
        counted_frame(1'b0, model_cnt);
        counted_frame(1'b0, model_cnt);
        counted_frame(1'b0, model_cnt);
        counted_frame(1'b1, model_cnt);
        report_test("error counter", errs0);
    endtask

    initial begin
        i_clk           = 1'b0;
        i_rst_n         = 1'b0;
        i_rx            = 1'b0;
        i_comerr_mode   = 1'b0;
        i_comerr_config = 4'b1100;
        last_data       = '0;
        apply_reset();
        test_good_frames();
        test_short_read();
        test_bad_crc();
        test_coding_and_timeout();
        test_err_counter();
        $display("tests run: %0d, tests failed: %0d, failed checks: %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge i_clk);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYC);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== src.f ====
hv/owt_rx_pkg.sv
hv/owt_sym_if.sv
hv/owt_symbol_timer.sv
hv/owt_mcst_decoder.sv
hv/owt_crc8_serial.sv
hv/owt_frame_fsm.sv
hv/owt_com_err_mon.sv
hv/owt_rx_top.sv
bench/owt_rx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= owt_rx_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
